//--- build.f
rvExecPkg.sv
execBusIf.sv
integerUnit.sv
branchUnit.sv
memAccessUnit.sv
csrUnit.sv
retireCounter.sv
execControl.sv
execStage.sv
execStage_properties.sv
execStageTb.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module execStageTb -Mdir obj_dir

./obj_dir/VexecStageTb 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

//--- execStageTb.sv
// Self-checking testbench for the execute stage, compiled from build.f and run by run.sh
module execStageTb import rvExecPkg::*; ();

    localparam int numOps       = 200 + 60 + 20 * 6 + 12 + 2;
    localparam int timeoutLimit = 12 * numOps + 50;  // Cycles before giving up

    typedef struct packed {
        logic   we;
        wordT   data;
        regIdxT rd;
        logic   jmp;
        wordT   tgt;
        logic   isLoad;                         // Load with variable latency
        longint issueTime;
    } expectT;

    logic    clk;
    logic    arstN;
    logic    issueValid;
    unitSelT issueUnit;
    execOpT  issueOp;
    wordT    issueOpA;
    wordT    issueOpB;
    wordT    issueOffset;
    wordT    issueNpc;
    regIdxT  issueRd;
    logic    memRead;
    logic    memWrite;
    wordT    memAddr;
    byteEnT  memByteEn;
    wordT    memWdata;
    logic    memRvalid = 1'b0;
    wordT    memRdata  = '0;
    logic    wbValid;
    logic    wbWe;
    regIdxT  wbRd;
    wordT    wbData;
    logic    jumpValid;
    wordT    jumpAddr;
    logic    busy;

    logic [31:0] lfsr    = 32'd12;              // Stimulus bits
    logic [31:0] latLfsr = 32'd12;              // Memory latency bits
    wordT        memModel [64];
    wordT        shadowMem [64];
    wordT        shadowMscratch;
    int          retiredCount;
    int          cycles;
    expectT      expQ [$];
    expectT      cur;
    logic [1:0]  lat;
    logic [2:0]  waitCnt;
    logic [5:0]  rdIdx;
    execOpT      loadOps [5] = '{opLb, opLbu, opLh, opLhu, opLw};
    execOpT      storeOps [3] = '{opSb, opSh, opSw};
    execOpT      csrOps [6] = '{opCsrrw, opCsrrwi, opCsrrs, opCsrrsi, opCsrrc, opCsrrci};

    execStage execStage_inst (.*);

    bind execStage execStage_properties props_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // x^32+x^22+x^2+x+1
    endfunction

    function automatic wordT takeBits(int n);
        wordT r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};          // One step per bit
            lfsr = lfsrStep(lfsr);
        end
        return r;
    endfunction

    function automatic wordT initWord(int idx);
        return wordT'((idx + 1) * 32'h9E3779B9) ^ wordT'(idx); // Differs per word
    endfunction

    task automatic checkValue(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model updating shadow memory, mscratch and retire count
    function automatic void refExec(input unitSelT u, input execOpT op, input wordT a,
                                    input wordT b, input wordT off, input wordT npc,
                                    input regIdxT rd, output logic hasWb, output logic we,
                                    output wordT data, output logic jmp, output wordT tgt);
        wordT       addr;
        wordT       word;
        wordT       old;
        wordT       src;
        logic [5:0] idx;
        logic [4:0] field;
        int         sh;
        hasWb = 1'b1;
        we    = 1'b1;
        jmp   = 1'b0;
        tgt   = '0;
        addr  = a + b;
        idx   = addr[7:2];
        sh    = 8 * int'(addr[1:0]);
        word  = shadowMem[idx] >> sh;           // Selected lane at bit 0
        field = b[16:12];
        case (u)
            unitInt: begin
                case (op)
                    opSub:   data = a - b;
                    opSlt:   data = {31'b0, $signed(a) < $signed(b)};
                    opSltu:  data = {31'b0, a < b};
                    opXor:   data = a ^ b;
                    opOr:    data = a | b;
                    opAnd:   data = a & b;
                    opSll:   data = a << b[4:0];
                    opSrl:   data = a >> b[4:0];
                    opSra:   data = $signed(a) >>> b[4:0];
                    default: data = a + b;
                endcase
            end
            unitBranch: begin
                case (op)
                    opBeq:   jmp = (a == b);
                    opBne:   jmp = (a != b);
                    opBlt:   jmp = ($signed(a) < $signed(b));
                    opBltu:  jmp = (a < b);
                    opBge:   jmp = ($signed(a) >= $signed(b));
                    opBgeu:  jmp = (a >= b);
                    default: jmp = 1'b1;        // JAL and JALR
                endcase
                we   = (op == opJal) || (op == opJalr);
                data = npc + 4;
                tgt  = (op == opJalr) ? (addr & ~32'd1) : (npc + off);
            end
            unitMem: begin
                case (op)
                    opLb:    data = {{24{word[7]}}, word[7:0]};
                    opLbu:   data = {24'b0, word[7:0]};
                    opLh:    data = {{16{word[15]}}, word[15:0]};
                    opLhu:   data = {16'b0, word[15:0]};
                    opLw:    data = shadowMem[idx];
                    default: hasWb = 1'b0;      // Stores retire without write-back
                endcase
                if (op == opSb) shadowMem[idx][sh +: 8] = off[7:0];
                if (op == opSh) shadowMem[idx][sh +: 16] = off[15:0];
                if (op == opSw) shadowMem[idx] = off;
            end
            default: begin
                case (b[11:0])
                    csrMscratch: old = shadowMscratch;
                    csrMinstret: old = wordT'(retiredCount);
                    default:     old = '0;      // minstreth stays zero here
                endcase
                if ((op == opCsrrwi) || (op == opCsrrsi) || (op == opCsrrci)) begin
                    src = {27'b0, field};
                end else begin
                    src = a;
                end
                data = old;
                we   = (rd != 0);
                if (b[11:0] == csrMscratch) begin
                    if ((op == opCsrrw) || (op == opCsrrwi)) begin
                        shadowMscratch = src;
                    end
                    if (((op == opCsrrs) || (op == opCsrrsi)) && (field != 0)) begin
                        shadowMscratch = old | src;
                    end
                    if (((op == opCsrrc) || (op == opCsrrci)) && (field != 0)) begin
                        shadowMscratch = old & ~src;
                    end
                end
            end
        endcase
        retiredCount++;
    endfunction

    // Issue one operation on a rising edge and return once the stage is idle again
    task automatic sendOp(input unitSelT u, input execOpT op, input wordT a, input wordT b,
                          input wordT off, input wordT npc, input regIdxT rd);
        expectT e;
        logic   hasWb;
        logic   we;
        logic   jmp;
        wordT   data;
        wordT   tgt;
        refExec(u, op, a, b, off, npc, rd, hasWb, we, data, jmp, tgt);
        e.we        = we;
        e.data      = data;
        e.rd        = rd;
        e.jmp       = jmp;
        e.tgt       = tgt;
        e.isLoad    = (u == unitMem);
        e.issueTime = $time;
        if (hasWb) expQ.push_back(e);
        issueValid  <= 1'b1;
        issueUnit   <= u;
        issueOp     <= op;
        issueOpA    <= a;
        issueOpB    <= b;
        issueOffset <= off;
        issueNpc    <= npc;
        issueRd     <= rd;
        @(posedge clk);
        issueValid <= 1'b0;
        do @(posedge clk); while (busy);
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model with a latency of 1 to 4 cycles
    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < 64; i++) memModel[i] <= initWord(i);
            memRvalid <= 1'b0;
            waitCnt   <= '0;
        end else begin
            memRvalid <= 1'b0;
            if (memWrite) begin
                for (int i = 0; i < 4; i++) begin
                    if (memByteEn[i]) memModel[memAddr[7:2]][8*i +: 8] <= memWdata[8*i +: 8];
                end
            end
            if (memRead) begin
                lat     = {1'b0, latLfsr[0]};
                latLfsr = lfsrStep(latLfsr);
                lat     = {lat[0], latLfsr[0]};
                latLfsr = lfsrStep(latLfsr);
                waitCnt <= 3'd1 + lat;
                rdIdx   <= memAddr[7:2];
            end else if (waitCnt != 0) begin
                if (waitCnt == 1) begin
                    memRvalid <= 1'b1;          // Single-cycle response
                    memRdata  <= memModel[rdIdx];
                end
                waitCnt <= waitCnt - 1'b1;
            end
        end
    end

    // Compare every write-back or jump strobe against the oldest expectation
    always @(posedge clk) begin
        if (arstN && (wbValid || jumpValid)) begin
            if (expQ.size() == 0) begin
                $display("The DUT raised a strobe with no operation outstanding");
                $display("Result: FAILED");
                $fatal(1, "Unexpected strobe");
            end else begin
                cur = expQ.pop_front();
                checkValue("wbValid", wordT'(wbValid), 1);
                checkValue("wbWe", wordT'(wbWe), wordT'(cur.we));
                checkValue("wbRd", wordT'(wbRd), wordT'(cur.rd));
                if (cur.we) checkValue("wbData", wbData, cur.data);
                checkValue("jumpValid", wordT'(jumpValid), wordT'(cur.jmp));
                if (cur.jmp) checkValue("jumpAddr", jumpAddr, cur.tgt);
                if (!cur.isLoad) begin
                    checkValue("wbValid delay", wordT'($time - cur.issueTime), 30);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > timeoutLimit) begin
                $display("The run timed out after %0d cycles", cycles);
                $display("Result: FAILED");
                $fatal(1, "Timeout");
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        wordT       a;
        wordT       base;
        wordT       addr;
        execOpT     op;
        logic [1:0] lane;
        logic [4:0] field;
        arstN       = 1'b1;
        issueValid  = 1'b0;
        issueUnit   = unitInt;
        issueOp     = opAdd;
        issueOpA    = '0;
        issueOpB    = '0;
        issueOffset = '0;
        issueNpc    = '0;
        issueRd     = '0;
        shadowMscratch = '0;
        retiredCount   = 0;
        for (int i = 0; i < 64; i++) shadowMem[i] = initWord(i);
        #1 arstN = 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        repeat (5) begin                        // Quiet after reset
            @(posedge clk);
            checkValue("idle strobes", {wbValid, jumpValid, memRead, memWrite, busy}, '0);
        end
        repeat (200) begin
            op = execOpT'(takeBits(4) % 10);
            sendOp(unitInt, op, takeBits(32), takeBits(32), '0, '0, regIdxT'(takeBits(5)));
        end
        repeat (60) begin
            a  = takeBits(32);
            op = execOpT'(takeBits(3));
            sendOp(unitBranch, op, a, (takeBits(2) == 0) ? a : takeBits(32), takeBits(32),
                   takeBits(32), regIdxT'(takeBits(5)));
        end
        repeat (20) begin                       // Store followed by every load form
            addr = takeBits(6) << 2;
            op   = storeOps[takeBits(2) % 3];
            if (op == opSb) lane = 2'(takeBits(2));
            else if (op == opSh) lane = 2'(takeBits(1) << 1);
            else lane = 2'd0;
            base = takeBits(32);
            sendOp(unitMem, op, base, addr + lane - base, takeBits(32), '0, '0);
            for (int k = 0; k < 5; k++) begin
                lane = (k < 2) ? 2'(takeBits(2)) : (k < 4) ? 2'(takeBits(1) << 1) : 2'd0;
                base = takeBits(32);
                sendOp(unitMem, loadOps[k], base, addr + lane - base, '0, '0,
                       regIdxT'(takeBits(5)));
            end
        end
        for (int i = 0; i < 12; i++) begin      // Second half with zero source
            field = (i < 6) ? (5'(takeBits(5)) | 5'd1) : 5'd0;
            sendOp(unitCsr, csrOps[i % 6], takeBits(32), {15'b0, field, csrMscratch},
                   '0, '0, (i == 9) ? 5'd0 : regIdxT'(takeBits(4) + 1));
        end
        sendOp(unitCsr, opCsrrs, '0, {20'b0, csrMinstret}, '0, '0, 5'd7);
        sendOp(unitCsr, opCsrrs, '0, {20'b0, csrMinstretH}, '0, '0, 5'd8);
        repeat (3) @(posedge clk);
        if (expQ.size() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("%0d expected write-back strobes never came", expQ.size());
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- execStage_properties.sv
// Concurrent checks on the execute-stage strobe protocol, bound into execStage by the testbench
module execStage_properties (
    input logic clk,
    input logic arstN,
    input logic issueValid,
    input logic busy,
    input logic wbValid,
    input logic wbWe,
    input logic jumpValid,
    input logic memRead,
    input logic memWrite
);

    ////////////////////////////////////////////////////////////
    // Handshake
    noIssueWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
        busy |-> !issueValid)
        else $error("Issue strobe while the stage is busy");

    wbOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        wbValid |=> !wbValid)
        else $error("Write-back strobe longer than one cycle");

    jumpOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        jumpValid |=> !jumpValid)
        else $error("Jump strobe longer than one cycle");

    noReadAndWrite: assert property (@(posedge clk) disable iff (!arstN)
        !(memRead && memWrite))
        else $error("Memory read and write in the same cycle");

    // Everything quiet while reset is held
    quietInReset: assert property (@(posedge clk)
        !arstN |-> !(wbValid || wbWe || jumpValid || memRead || memWrite || busy))
        else $error("Strobe or busy high during reset");

endmodule

//--- execStage.sv
// RV32I execute stage top level joining the control FSM, the data units and the counters
module execStage import rvExecPkg::*; #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    issueValid,
    input  unitSelT issueUnit,
    input  execOpT  issueOp,
    input  wordT    issueOpA,
    input  wordT    issueOpB,
    input  wordT    issueOffset,
    input  wordT    issueNpc,
    input  regIdxT  issueRd,
    output logic    memRead,
    output logic    memWrite,
    output wordT    memAddr,
    output byteEnT  memByteEn,
    output wordT    memWdata,
    input  logic    memRvalid,
    input  wordT    memRdata,
    output logic    wbValid,
    output logic    wbWe,
    output regIdxT  wbRd,
    output wordT    wbData,
    output logic    jumpValid,
    output wordT    jumpAddr,
    output logic    busy
);

    wordT   intResult, jumpTarget, linkValue, loadValue, csrResult;
    wordT   unitAddr, unitWdata, rdataToUnit;
    byteEnT unitByteEn;
    logic   jumpTaken, linkWe, isLoad, csrWe, csrCommit, retire;
    logic [COUNTER_WIDTH-1:0] cycleCount, instretCount;

    execBusIf bus ();

    execControl ctrl_inst (
        .clk, .arstN, .issueValid, .issueUnit, .issueOp, .issueOpA, .issueOpB,
        .issueOffset, .issueNpc, .issueRd, .bus(bus.ctrl),
        .intResult, .jumpTaken, .jumpTarget, .linkValue, .linkWe,
        .memAddr(unitAddr), .memByteEn(unitByteEn), .memWdata(unitWdata),
        .isLoad, .loadValue, .csrResult, .csrWe, .memRvalid, .memRdata,
        .memRead, .memWrite, .memAddrOut(memAddr), .memByteEnOut(memByteEn),
        .memWdataOut(memWdata), .rdataToUnit, .wbValid, .wbWe, .wbRd, .wbData,
        .jumpValid, .jumpAddr, .busy, .csrCommit, .retire
    );

    retireCounter #(.COUNTER_WIDTH(COUNTER_WIDTH)) counter_inst (
        .clk, .arstN, .retire, .cycleCount, .instretCount
    );

    ////////////////////////////////////////////////////////////
    // Data units
    integerUnit int_inst (.bus(bus.unit), .result(intResult));

    branchUnit branch_inst (
        .bus(bus.unit), .jumpTaken, .jumpTarget, .linkValue, .linkWe
    );

    memAccessUnit mem_inst (
        .bus(bus.unit), .rdata(rdataToUnit), .memAddr(unitAddr),
        .memByteEn(unitByteEn), .memWdata(unitWdata), .isLoad, .loadValue
    );

    csrUnit #(.COUNTER_WIDTH(COUNTER_WIDTH)) csr_inst (
        .clk, .arstN, .bus(bus.unit), .csrCommit, .cycleCount, .instretCount,
        .csrResult, .csrWe
    );

endmodule

//--- execControl.sv
// Execute-stage control FSM capturing issues, waiting on memory and driving the strobes
module execControl import rvExecPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    issueValid,
    input  unitSelT issueUnit,
    input  execOpT  issueOp,
    input  wordT    issueOpA,
    input  wordT    issueOpB,
    input  wordT    issueOffset,
    input  wordT    issueNpc,
    input  regIdxT  issueRd,
    execBusIf.ctrl  bus,
    input  wordT    intResult,
    input  logic    jumpTaken,
    input  wordT    jumpTarget,
    input  wordT    linkValue,
    input  logic    linkWe,
    input  wordT    memAddr,
    input  byteEnT  memByteEn,
    input  wordT    memWdata,
    input  logic    isLoad,
    input  wordT    loadValue,
    input  wordT    csrResult,
    input  logic    csrWe,
    input  logic    memRvalid,
    input  wordT    memRdata,
    output logic    memRead,
    output logic    memWrite,
    output wordT    memAddrOut,
    output byteEnT  memByteEnOut,
    output wordT    memWdataOut,
    output wordT    rdataToUnit,
    output logic    wbValid,
    output logic    wbWe,
    output regIdxT  wbRd,
    output wordT    wbData,
    output logic    jumpValid,
    output wordT    jumpAddr,
    output logic    busy,
    output logic    csrCommit,
    output logic    retire
);

    execStateT state;
    logic      memOp;                           // Memory unit selected
    logic      inExec;
    wordT      exData;                          // Write-back value by unit
    logic      exWe;

    assign memOp        = (bus.unitSel == unitMem);
    assign inExec       = (state == stExec);
    assign memRead      = inExec && memOp && isLoad;  // One cycle, t+1
    assign memWrite     = inExec && memOp && !isLoad;
    assign memAddrOut   = memAddr;
    assign memByteEnOut = memByteEn;
    assign memWdataOut  = memWdata;
    assign rdataToUnit  = memRdata;             // Extended before registering
    assign csrCommit    = inExec && (bus.unitSel == unitCsr);
    assign retire       = (state == stWriteBack); // Includes stores
    assign busy         = (state != stIdle);

    always_comb begin
        case (bus.unitSel)
            unitBranch: begin
                exData = linkValue;
                exWe   = linkWe;                // Plain branches write nothing
            end
            unitCsr: begin
                exData = csrResult;
                exWe   = csrWe;
            end
            default: begin
                exData = intResult;
                exWe   = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // FSM and strobes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= stIdle;
            wbValid   <= 1'b0;
            wbWe      <= 1'b0;
            jumpValid <= 1'b0;
        end else begin
            wbValid   <= 1'b0;                  // Strobes last one cycle
            wbWe      <= 1'b0;
            jumpValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (issueValid) begin
                        state <= stExec;
                    end
                end
                stExec: begin
                    if (memOp && isLoad) begin
                        state <= stMemWait;
                    end else begin
                        state     <= stWriteBack;
                        wbValid   <= !memOp;    // Stores retire silently
                        wbWe      <= !memOp && exWe;
                        jumpValid <= (bus.unitSel == unitBranch) && jumpTaken;
                    end
                end
                stMemWait: begin
                    if (memRvalid) begin
                        state   <= stWriteBack;
                        wbValid <= 1'b1;
                        wbWe    <= 1'b1;
                    end
                end
                default: state <= stIdle;       // Write-back lasts one cycle
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Operation and result registers
    always_ff @(posedge clk) begin
        if ((state == stIdle) && issueValid) begin
            bus.opA     <= issueOpA;
            bus.opB     <= issueOpB;
            bus.offset  <= issueOffset;
            bus.npc     <= issueNpc;
            bus.unitSel <= issueUnit;
            bus.op      <= issueOp;
            bus.rd      <= issueRd;
        end
        if (inExec) begin
            wbRd     <= bus.rd;
            wbData   <= exData;
            jumpAddr <= jumpTarget;
        end else if ((state == stMemWait) && memRvalid) begin
            wbData <= loadValue;                // Memory response
        end
    end

endmodule

//--- retireCounter.sv
// Cycle and retired-instruction counters feeding mcycle and minstret
module retireCounter import rvExecPkg::*; #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     retire,
    output logic [COUNTER_WIDTH-1:0] cycleCount,
    output logic [COUNTER_WIDTH-1:0] instretCount
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cycleCount   <= '0;
            instretCount <= '0;
        end else begin
            cycleCount <= cycleCount + 1'b1;    // Every cycle
            if (retire) begin
                instretCount <= instretCount + 1'b1;
            end
        end
    end

endmodule

//--- csrUnit.sv
// CSR unit decoding read, write, set and clear, holding mscratch and reading the counters
module csrUnit import rvExecPkg::*; #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                     clk,
    input  logic                     arstN,
    execBusIf.unit                   bus,
    input  logic                     csrCommit,
    input  logic [COUNTER_WIDTH-1:0] cycleCount,
    input  logic [COUNTER_WIDTH-1:0] instretCount,
    output wordT                     csrResult,
    output logic                     csrWe
);

    csrAddrT addr;                              // opB[11:0]
    regIdxT  srcField;                          // rs1 or immediate, opB[16:12]
    csrOpT   csrOp;
    wordT    src;
    wordT    newValue;
    wordT    mscratch;
    logic    doWrite;

    assign addr     = bus.opB[11:0];
    assign srcField = bus.opB[16:12];
    assign csrWe    = (bus.rd != '0);

    always_comb begin
        case (bus.op)
            opCsrrw, opCsrrwi: csrOp = csrWrite;
            opCsrrs, opCsrrsi: csrOp = csrSet;
            opCsrrc, opCsrrci: csrOp = csrClear;
            default:           csrOp = csrNone;
        endcase
        case (bus.op)
            opCsrrwi, opCsrrsi, opCsrrci: src = {27'b0, srcField}; // Immediate forms
            default:                      src = bus.opA;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Read old value, build new one
    always_comb begin
        case (addr)
            csrMscratch:  csrResult = mscratch;
            csrMcycle:    csrResult = cycleCount[31:0];
            csrMcycleH:   csrResult = wordT'(cycleCount >> 32);
            csrMinstret:  csrResult = instretCount[31:0];
            csrMinstretH: csrResult = wordT'(instretCount >> 32);
            default:      csrResult = '0;
        endcase
        case (csrOp)
            csrSet:   newValue = csrResult | src;
            csrClear: newValue = csrResult & ~src;
            default:  newValue = src;
        endcase
        // Set and clear with a zero field only read
        doWrite = (csrOp == csrWrite) || ((csrOp != csrNone) && (srcField != '0));
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mscratch <= '0;
        end else if (csrCommit && doWrite && (addr == csrMscratch)) begin
            mscratch <= newValue;               // Counters stay read-only
        end
    end

endmodule

//--- memAccessUnit.sv
// Memory access unit forming store lanes and byte enables and extending load data
module memAccessUnit import rvExecPkg::*; (
    execBusIf.unit bus,
    input  wordT   rdata,
    output wordT   memAddr,
    output byteEnT memByteEn,
    output wordT   memWdata,
    output logic   isLoad,
    output wordT   loadValue
);

    logic [1:0] lane;                           // Byte offset in word
    wordT       shifted;                        // Read word moved to lane 0

    assign memAddr = bus.opA + bus.opB;         // Issuer keeps it aligned
    assign lane    = memAddr[1:0];
    assign shifted = rdata >> {lane, 3'b000};

    always_comb begin
        case (bus.op)
            opLb, opLbu, opLh, opLhu, opLw: isLoad = 1'b1;
            default:                        isLoad = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Store side, data comes in offset
    always_comb begin
        case (bus.op)
            opSb: begin
                memByteEn = byteEnT'(4'b0001 << lane);
                memWdata  = {24'b0, bus.offset[7:0]} << {lane, 3'b000};
            end
            opSh: begin
                memByteEn = byteEnT'(4'b0011 << lane);
                memWdata  = {16'b0, bus.offset[15:0]} << {lane, 3'b000};
            end
            opSw: begin
                memByteEn = 4'b1111;
                memWdata  = bus.offset;
            end
            default: begin                      // Loads write nothing
                memByteEn = 4'b0000;
                memWdata  = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Load side
    always_comb begin
        case (bus.op)
            opLb:    loadValue = {{24{shifted[7]}}, shifted[7:0]};
            opLbu:   loadValue = {24'b0, shifted[7:0]};
            opLh:    loadValue = {{16{shifted[15]}}, shifted[15:0]};
            opLhu:   loadValue = {16'b0, shifted[15:0]};
            default: loadValue = rdata;         // LW
        endcase
    end

endmodule

//--- branchUnit.sv
// Combinational branch unit computing the condition, jump target and link value
module branchUnit import rvExecPkg::*; (
    execBusIf.unit bus,
    output logic   jumpTaken,
    output wordT   jumpTarget,
    output wordT   linkValue,
    output logic   linkWe
);

    wordT regTarget;                            // JALR base plus offset
    logic isJump;                               // Unconditional

    assign regTarget = bus.opA + bus.opB;
    assign isJump    = (bus.op == opJal) || (bus.op == opJalr);
    assign linkValue = bus.npc + 32'd4;         // Return address
    assign linkWe    = isJump;                  // Only jumps write rd

    ////////////////////////////////////////////////////////////
    // Condition
    always_comb begin
        case (bus.op)
            opBeq:   jumpTaken = (bus.opA == bus.opB);
            opBne:   jumpTaken = (bus.opA != bus.opB);
            opBlt:   jumpTaken = ($signed(bus.opA) < $signed(bus.opB));
            opBltu:  jumpTaken = (bus.opA < bus.opB);
            opBge:   jumpTaken = ($signed(bus.opA) >= $signed(bus.opB));
            opBgeu:  jumpTaken = (bus.opA >= bus.opB);
            default: jumpTaken = isJump;        // JAL, JALR always
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Target
    always_comb begin
        if (bus.op == opJalr) begin
            jumpTarget = {regTarget[31:1], 1'b0}; // Bit 0 cleared
        end else begin
            jumpTarget = bus.npc + bus.offset;  // PC relative
        end
    end

endmodule

//--- integerUnit.sv
// Combinational integer unit for arithmetic, compare, logic and shift operations
module integerUnit import rvExecPkg::*; (
    execBusIf.unit bus,
    output wordT   result
);

    logic [4:0] shamt;                          // Shift amount

    assign shamt = bus.opB[4:0];

    always_comb begin
        case (bus.op)
            opSub:   result = bus.opA - bus.opB;
            opSlt:   result = wordT'($signed(bus.opA) < $signed(bus.opB));
            opSltu:  result = wordT'(bus.opA < bus.opB);
            opXor:   result = bus.opA ^ bus.opB;
            opOr:    result = bus.opA | bus.opB;
            opAnd:   result = bus.opA & bus.opB;
            opSll:   result = bus.opA << shamt;
            opSrl:   result = bus.opA >> shamt;
            opSra:   result = wordT'($signed(bus.opA) >>> shamt); // Keeps sign bit
            default: result = bus.opA + bus.opB; // ADD and unused codes
        endcase
    end

endmodule

//--- execBusIf.sv
// Registered operation bus from the control FSM to the data units of the execute stage
interface execBusIf import rvExecPkg::*; ();

    wordT    opA;                               // First operand
    wordT    opB;                               // Second operand, CSR fields for CSR ops
    wordT    offset;                            // Immediate offset or store data
    wordT    npc;                               // Next PC
    unitSelT unitSel;                           // Target unit
    execOpT  op;                                // Code within the unit
    regIdxT  rd;                                // Destination register

    // Control FSM drives the registered fields
    modport ctrl (
        output opA, opB, offset, npc, unitSel, op, rd
    );

    // Data units only look
    modport unit (
        input opA, opB, offset, npc, unitSel, op, rd
    );

endinterface

//--- rvExecPkg.sv
// Shared types, operation codes and CSR addresses, imported by every execute-stage file
package rvExecPkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    typedef logic [31:0] wordT;                 // Data or address word
    typedef logic [4:0]  regIdxT;               // Register index
    typedef logic [11:0] csrAddrT;              // CSR address
    typedef logic [3:0]  byteEnT;               // Memory byte enables

    typedef enum logic [1:0] {
        unitInt, unitBranch, unitMem, unitCsr
    } unitSelT;

    // Generic codes, meaning given by the unit select
    typedef enum logic [3:0] {
        op0, op1, op2, op3, op4, op5, op6, op7, op8, op9
    } execOpT;

    ////////////////////////////////////////////////////////////
    // Per-unit names for the shared codes
    localparam execOpT opAdd = op0, opSub = op1, opSlt = op2, opSltu = op3;
    localparam execOpT opXor = op4, opOr = op5, opAnd = op6;
    localparam execOpT opSll = op7, opSrl = op8, opSra = op9;

    localparam execOpT opBeq = op0, opBne = op1, opBlt = op2, opBltu = op3;
    localparam execOpT opBge = op4, opBgeu = op5, opJal = op6, opJalr = op7;

    localparam execOpT opLb = op0, opLbu = op1, opLh = op2, opLhu = op3;
    localparam execOpT opLw = op4, opSb = op5, opSh = op6, opSw = op7;

    localparam execOpT opCsrrw = op0, opCsrrwi = op1, opCsrrs = op2;
    localparam execOpT opCsrrsi = op3, opCsrrc = op4, opCsrrci = op5;

    typedef enum logic [1:0] {
        csrNone, csrWrite, csrSet, csrClear
    } csrOpT;

    typedef enum logic [1:0] {
        stIdle, stExec, stMemWait, stWriteBack
    } execStateT;

    ////////////////////////////////////////////////////////////
    // Supported CSRs
    localparam csrAddrT csrMscratch  = 12'h340;
    localparam csrAddrT csrMcycle    = 12'hB00;
    localparam csrAddrT csrMinstret  = 12'hB02;
    localparam csrAddrT csrMcycleH   = 12'hB80;
    localparam csrAddrT csrMinstretH = 12'hB82;

endpackage
